//--- hw/nn_layer_pkg.sv
// Signed Q8.8 samples and wrapping Q16.16 accumulators, with no saturation anywhere.
// Field and array order inside the packed types is fixed, because the testbench packs them too.
`default_nettype none

package nn_layer_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_NEURONS = 6;
  localparam int SAMPLE_W    = 16;
  localparam int FRAC_W      = 8;
  localparam int ACC_W       = 32;
  localparam int GAIN_W      = 4;

  //////////////////////////////////////////////////////////////////////
  // Fixed-point types
  //////////////////////////////////////////////////////////////////////

  // Q8.8
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Q16.16, wraps on overflow
  typedef logic signed [ACC_W-1:0] acc_t;

  // One entry per neuron, neuron 0 in the low bits
  typedef sample_t [NUM_NEURONS-1:0] sample_vec_t;
  typedef acc_t    [NUM_NEURONS-1:0] acc_vec_t;

  //////////////////////////////////////////////////////////////////////
  // Layer configuration
  //////////////////////////////////////////////////////////////////////

  // Must stay static while a frame is being accumulated
  typedef struct packed {
    logic [GAIN_W-1:0] tap_gain;               // right shift on every tap
    logic              disable_non_linearity;  // sigmoid bypass
  } layer_cfg_t;

endpackage

`default_nettype wire

//--- hw/layer_input_stage.sv
// Every output lags its input by one cycle. The bias is held between first pulses.
// Taps are shifted arithmetically, so large gains drive small taps to 0 or -1.
`default_nettype none

module layer_input_stage (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              first,
  input  wire  nn_layer_pkg::sample_t      data,
  input  wire  nn_layer_pkg::sample_vec_t  taps,
  input  wire  nn_layer_pkg::sample_vec_t  bias,
  input  wire  [nn_layer_pkg::GAIN_W-1:0]  tap_gain,
  output logic                             first_r,
  output nn_layer_pkg::sample_t            data_r,
  output nn_layer_pkg::sample_vec_t        taps_r,
  output nn_layer_pkg::sample_vec_t        bias_r
);

  // Gain-scaled taps before the register
  nn_layer_pkg::sample_vec_t taps_scaled;

  always_comb begin
    for (int i = 0; i < nn_layer_pkg::NUM_NEURONS; i++) begin
      taps_scaled[i] = taps[i] >>> tap_gain;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Broadcast registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      first_r <= 1'b0;
      data_r  <= '0;
      taps_r  <= '0;
    end else begin
      first_r <= first;
      data_r  <= data;
      taps_r  <= taps_scaled;
    end
  end

  // Bias for the frame that starts with this pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      bias_r <= '0;
    end else if (first) begin
      bias_r <= bias;
    end
  end

endmodule

`default_nettype wire

//--- hw/neuron_mac.sv
// Signed 16x16 multiply with a 32-bit accumulator that wraps silently on overflow.
// The sum is complete in the cycle in which first_r marks the start of the next frame.
`default_nettype none

module neuron_mac (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          first_r,
  input  wire  nn_layer_pkg::sample_t  data_r,
  input  wire  nn_layer_pkg::sample_t  tap_r,
  output nn_layer_pkg::acc_t           sum
);

  // Q8.8 times Q8.8 gives Q16.16 directly
  nn_layer_pkg::acc_t product;

  always_comb begin
    product = nn_layer_pkg::acc_t'(data_r) * nn_layer_pkg::acc_t'(tap_r);
  end

  //////////////////////////////////////////////////////////////////////
  // Accumulator
  //////////////////////////////////////////////////////////////////////

  // first_r restarts the sum from the new frame's first product
  always_ff @(posedge clk) begin
    if (reset) begin
      sum <= '0;
    end else if (first_r) begin
      sum <= product;
    end else begin
      sum <= sum + product;
    end
  end

endmodule

`default_nettype wire

//--- hw/layer_output_stage.sv
// Frame length must be at least NUM_NEURONS, or the serial line is reloaded before it drains.
// The Q8.8 rounding truncates and the bias add wraps. Neither saturates.
`default_nettype none

module layer_output_stage (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              first_r,
  input  wire  nn_layer_pkg::acc_vec_t     sums,
  input  wire  nn_layer_pkg::sample_vec_t  bias_r,
  output nn_layer_pkg::acc_vec_t           neuron_sums,
  output nn_layer_pkg::sample_t            pre_bias,
  output nn_layer_pkg::sample_t            biased
);

  localparam int N = nn_layer_pkg::NUM_NEURONS;

  // Serial line of sums, entry 0 is the head
  nn_layer_pkg::acc_vec_t    out_line;
  // Bias of the frame that is being accumulated
  nn_layer_pkg::sample_vec_t frame_bias;
  // Bias line that moves in step with out_line
  nn_layer_pkg::sample_vec_t bias_line;

  //////////////////////////////////////////////////////////////////////
  // Parallel sums
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      neuron_sums <= '0;
    end else if (first_r) begin
      neuron_sums <= sums;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Serial lines
  //////////////////////////////////////////////////////////////////////

  // bias_r already holds the next frame's bias when first_r is high.
  // So keep the current frame's copy and hand it on at the frame boundary.
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_bias <= '0;
    end else if (first_r) begin
      frame_bias <= bias_r;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_line  <= '0;
      bias_line <= '0;
    end else if (first_r) begin
      out_line  <= sums;
      bias_line <= frame_bias;
    end else begin
      for (int i = 0; i < N - 1; i++) begin
        out_line[i]  <= out_line[i+1];
        bias_line[i] <= bias_line[i+1];
      end
      // Zeros fill in behind the last neuron
      out_line[N-1]  <= '0;
      bias_line[N-1] <= '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Head of line
  //////////////////////////////////////////////////////////////////////

  // Q16.16 down to Q8.8, upper bits dropped
  always_comb begin
    pre_bias = nn_layer_pkg::sample_t'(out_line[0] >>> nn_layer_pkg::FRAC_W);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      biased <= '0;
    end else begin
      biased <= pre_bias + bias_line[0];
    end
  end

endmodule

`default_nettype wire

//--- hw/hard_sigmoid.sv
// Piecewise-linear sigmoid x/4 + 0.5, clamped to 0.0 .. 1.0 in Q8.8.
// One cycle of latency in both modes. Bypass may change between samples.
`default_nettype none

module hard_sigmoid (
  input  wire                          clk,
  input  wire                          reset,
  input  wire                          bypass,
  input  wire  nn_layer_pkg::sample_t  data_in,
  output nn_layer_pkg::sample_t        data_out
);

  localparam int SLOPE_SHIFT = 2;
  localparam int HALF        = 1 << (nn_layer_pkg::FRAC_W - 1);
  localparam int ONE         = 1 << nn_layer_pkg::FRAC_W;

  // Cannot overflow. |x/4| + 0.5 stays well inside Q8.8
  nn_layer_pkg::sample_t scaled;
  nn_layer_pkg::sample_t clamped;

  always_comb begin
    scaled = (data_in >>> SLOPE_SHIFT) + nn_layer_pkg::sample_t'(HALF);
    if (scaled < 0) begin
      clamped = '0;
    end else if (scaled > nn_layer_pkg::sample_t'(ONE)) begin
      clamped = nn_layer_pkg::sample_t'(ONE);
    end else begin
      clamped = scaled;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else if (bypass) begin
      data_out <= data_in;
    end else begin
      data_out <= clamped;
    end
  end

endmodule

`default_nettype wire

//--- hw/fc_layer_top.sv
// Forward pass only. neuron_sums is valid 2 cycles after first, data_out 4+i cycles after.
// There is no output strobe, so the user times the outputs from first.
`default_nettype none

module fc_layer_top (
  input  wire                              clk,
  input  wire                              reset,
  input  wire                              first,
  input  wire  nn_layer_pkg::sample_t      data,
  input  wire  nn_layer_pkg::sample_vec_t  taps,
  input  wire  nn_layer_pkg::sample_vec_t  bias,
  input  wire  nn_layer_pkg::layer_cfg_t   cfg,
  output nn_layer_pkg::acc_vec_t           neuron_sums,
  output nn_layer_pkg::sample_t            data_out_pre,
  output nn_layer_pkg::sample_t            data_out
);

  logic                      first_r;
  nn_layer_pkg::sample_t     data_r;
  nn_layer_pkg::sample_vec_t taps_r;
  nn_layer_pkg::sample_vec_t bias_r;
  nn_layer_pkg::acc_vec_t    sums;
  nn_layer_pkg::sample_t     biased;

  //////////////////////////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////////////////////////

  layer_input_stage input_stage0 (
    .clk      (clk),
    .reset    (reset),
    .first    (first),
    .data     (data),
    .taps     (taps),
    .bias     (bias),
    .tap_gain (cfg.tap_gain),
    .first_r  (first_r),
    .data_r   (data_r),
    .taps_r   (taps_r),
    .bias_r   (bias_r)
  );

  // One MAC per neuron, same sample to all
  for (genvar i = 0; i < nn_layer_pkg::NUM_NEURONS; i++) begin : g_neuron
    neuron_mac neuron (
      .clk     (clk),
      .reset   (reset),
      .first_r (first_r),
      .data_r  (data_r),
      .tap_r   (taps_r[i]),
      .sum     (sums[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Output side
  //////////////////////////////////////////////////////////////////////

  layer_output_stage output_stage0 (
    .clk         (clk),
    .reset       (reset),
    .first_r     (first_r),
    .sums        (sums),
    .bias_r      (bias_r),
    .neuron_sums (neuron_sums),
    .pre_bias    (data_out_pre),
    .biased      (biased)
  );

  hard_sigmoid sigmoid0 (
    .clk      (clk),
    .reset    (reset),
    .bypass   (cfg.disable_non_linearity),
    .data_in  (biased),
    .data_out (data_out)
  );

endmodule

`default_nettype wire

//--- verification/fc_layer_asserts.sv
// Reference model of the layer that sees only the top-level ports. Assumes a single reset.
// Results are checked from the first complete frame on. Frames must be NUM_NEURONS or longer.
`default_nettype none

module fc_layer_asserts (
  input wire                             clk,
  input wire                             reset,
  input wire                             first,
  input wire nn_layer_pkg::sample_t      data,
  input wire nn_layer_pkg::sample_vec_t  taps,
  input wire nn_layer_pkg::sample_vec_t  bias,
  input wire nn_layer_pkg::layer_cfg_t   cfg,
  input wire nn_layer_pkg::acc_vec_t     neuron_sums,
  input wire nn_layer_pkg::sample_t      data_out_pre,
  input wire nn_layer_pkg::sample_t      data_out
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N      = nn_layer_pkg::NUM_NEURONS;
  localparam int IDX_W  = $clog2(N + 1);
  localparam int HALF_Q = 128;  // 0.5 in Q8.8
  localparam int ONE_Q  = 256;  // 1.0 in Q8.8

  int fail_count = 0;
  int frames;
  logic first_d1;
  logic first_d2;
  nn_layer_pkg::acc_vec_t    acc;
  nn_layer_pkg::acc_vec_t    done_sums;
  nn_layer_pkg::sample_vec_t bias_cur;
  nn_layer_pkg::sample_vec_t bias_prev;
  nn_layer_pkg::sample_vec_t ser_pre;
  nn_layer_pkg::sample_vec_t ser_bias;
  logic [IDX_W-1:0]          ser_idx;
  logic                      ser_live;
  logic                      head_live;
  nn_layer_pkg::sample_t     head_pre;
  nn_layer_pkg::sample_t     head_bias;
  nn_layer_pkg::sample_t     exp_biased;
  nn_layer_pkg::sample_t     exp_out;
  logic                      valid_b;
  logic                      valid_o;

  // Q8.8 sample times gain-shifted Q8.8 tap, as a wrapping Q16.16 value
  function automatic nn_layer_pkg::acc_t tap_product(input nn_layer_pkg::sample_t x,
                                                     input nn_layer_pkg::sample_t tap,
                                                     input logic [nn_layer_pkg::GAIN_W-1:0] gain);
    int scaled;
    scaled = int'(tap) >>> gain;
    return nn_layer_pkg::acc_t'(int'(x) * scaled);
  endfunction

  // x/4 + 0.5, clamped to 0.0 .. 1.0
  function automatic nn_layer_pkg::sample_t sigmoid_expect(input nn_layer_pkg::sample_t x);
    int y;
    y = (int'(x) >>> 2) + HALF_Q;
    if (y < 0) y = 0;
    if (y > ONE_Q) y = ONE_Q;
    return nn_layer_pkg::sample_t'(y);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Frame accumulation, straight from the inputs
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      frames    <= 0;
      first_d1  <= 1'b0;
      first_d2  <= 1'b0;
      acc       <= '0;
      done_sums <= '0;
      bias_cur  <= '0;
      bias_prev <= '0;
    end else begin
      first_d1 <= first;
      first_d2 <= first_d1;
      for (int i = 0; i < N; i++) begin
        if (first) begin
          acc[i] <= tap_product(data, taps[i], cfg.tap_gain);
        end else begin
          acc[i] <= acc[i] + tap_product(data, taps[i], cfg.tap_gain);
        end
      end
      if (first) begin
        frames    <= frames + 1;
        done_sums <= acc;
        bias_prev <= bias_cur;
        bias_cur  <= bias;
      end
    end
  end

  // Neuron ser_idx is due on data_out_pre in this cycle
  always_comb begin
    head_live = ser_live && (ser_idx < IDX_W'(N));
    head_pre  = '0;
    head_bias = '0;
    if (head_live) begin
      head_pre  = ser_pre[ser_idx];
      head_bias = ser_bias[ser_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ser_pre    <= '0;
      ser_bias   <= '0;
      ser_idx    <= IDX_W'(N);
      ser_live   <= 1'b0;
      exp_biased <= '0;
      exp_out    <= '0;
      valid_b    <= 1'b0;
      valid_o    <= 1'b0;
    end else begin
      if (first_d1) begin
        for (int i = 0; i < N; i++) begin
          ser_pre[i] <= nn_layer_pkg::sample_t'(done_sums[i] >>> nn_layer_pkg::FRAC_W);
        end
        ser_bias <= bias_prev;
        ser_idx  <= '0;
        ser_live <= (frames >= 2);
      end else if (head_live) begin
        ser_idx <= ser_idx + IDX_W'(1);
      end
      exp_biased <= head_pre + head_bias;
      valid_b    <= head_live;
      // Bypass as seen when the sigmoid register loads
      if (cfg.disable_non_linearity) begin
        exp_out <= exp_biased;
      end else begin
        exp_out <= sigmoid_expect(exp_biased);
      end
      valid_o <= valid_b;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  a_reset_zero: assert property (@(posedge clk) (reset && $past(reset)) |->
      (neuron_sums == '0 && data_out_pre == '0 && data_out == '0))
    else begin
      fail_count++;
      $error("CHECK FAILED at %0t: outputs not zero during reset", $time);
    end

  a_idle_zero: assert property (@(posedge clk) disable iff (reset) (frames < 2) |->
      (neuron_sums == '0 && data_out_pre == '0 && data_out == '0))
    else begin
      fail_count++;
      $error("CHECK FAILED at %0t: outputs not zero before the first complete frame", $time);
    end

  a_sums: assert property (@(posedge clk) disable iff (reset) (first_d2 && frames >= 2) |->
      (neuron_sums == done_sums))
    else begin
      fail_count++;
      $error("CHECK FAILED at %0t: neuron_sums %h, expected %h", $time,
             $sampled(neuron_sums), $sampled(done_sums));
    end

  a_pre: assert property (@(posedge clk) disable iff (reset) head_live |->
      (data_out_pre == head_pre))
    else begin
      fail_count++;
      $error("CHECK FAILED at %0t: data_out_pre %h, expected %h", $time,
             $sampled(data_out_pre), $sampled(head_pre));
    end

  a_out: assert property (@(posedge clk) disable iff (reset) valid_o |->
      (data_out == exp_out))
    else begin
      fail_count++;
      $error("CHECK FAILED at %0t: data_out %h, expected %h", $time,
             $sampled(data_out), $sampled(exp_out));
    end

endmodule

`default_nettype wire

//--- verification/fc_layer_tb.sv
// Random frames run back to back after one reset. The bound assertion module does all checks.
// Samples and taps stay below 4.0 in magnitude, so the Q16.16 sums do not wrap.
`default_nettype none

module fc_layer_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N             = nn_layer_pkg::NUM_NEURONS;
  localparam int FLUSH_LEN     = 11;
  localparam int TOTAL_FRAMES  = 25;
  localparam int MAX_FRAME_LEN = FLUSH_LEN;
  localparam int WATCHDOG_NS   = TOTAL_FRAMES * MAX_FRAME_LEN * 10 + 1000;

  logic                      clk;
  logic                      reset;
  logic                      first;
  nn_layer_pkg::sample_t     data;
  nn_layer_pkg::sample_vec_t taps;
  nn_layer_pkg::sample_vec_t bias;
  nn_layer_pkg::layer_cfg_t  cfg;
  nn_layer_pkg::acc_vec_t    neuron_sums;
  nn_layer_pkg::sample_t     data_out_pre;
  nn_layer_pkg::sample_t     data_out;

  int tests_run;
  int tests_failed;
  int fails_before;

  fc_layer_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .first        (first),
    .data         (data),
    .taps         (taps),
    .bias         (bias),
    .cfg          (cfg),
    .neuron_sums  (neuron_sums),
    .data_out_pre (data_out_pre),
    .data_out     (data_out)
  );

  bind fc_layer_top fc_layer_asserts asserts0 (
    .clk          (clk),
    .reset        (reset),
    .first        (first),
    .data         (data),
    .taps         (taps),
    .bias         (bias),
    .cfg          (cfg),
    .neuron_sums  (neuron_sums),
    .data_out_pre (data_out_pre),
    .data_out     (data_out)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // Raw range +-1023, just under 4.0
  function automatic nn_layer_pkg::sample_t small_value();
    int r;
    r = int'($urandom_range(2046)) - 1023;
    return nn_layer_pkg::sample_t'(r);
  endfunction

  function automatic nn_layer_pkg::sample_vec_t small_vector();
    nn_layer_pkg::sample_vec_t v;
    for (int i = 0; i < N; i++) begin
      v[i] = small_value();
    end
    return v;
  endfunction

  // Two neurons pushed far high, two far low, two left near the linear region
  function automatic nn_layer_pkg::sample_vec_t clamp_bias();
    nn_layer_pkg::sample_vec_t v;
    v = small_vector();
    v[0] = 16'sh4000;
    v[1] = 16'sh3000;
    v[2] = -16'sh4000;
    v[3] = -16'sh3000;
    return v;
  endfunction

  task automatic run_frame(input int len, input logic [nn_layer_pkg::GAIN_W-1:0] gain,
                           input logic bypass, input nn_layer_pkg::sample_vec_t frame_bias);
    for (int c = 0; c < len; c++) begin
      @(posedge clk);
      #1;
      first = (c == 0);
      if (c == 0) begin
        cfg.tap_gain              = gain;
        cfg.disable_non_linearity = bypass;
        bias                      = frame_bias;
      end
      data = small_value();
      taps = small_vector();
    end
  endtask

  // Zero frame that lets the previous frame drain out of the serial path
  task automatic flush_frame();
    @(posedge clk);
    #1;
    first = 1'b1;
    data  = '0;
    taps  = '0;
    bias  = '0;
    repeat (FLUSH_LEN - 1) begin
      @(posedge clk);
      #1;
      first = 1'b0;
    end
  endtask

  task automatic end_test(input string name);
    int fails;
    fails = dut0.asserts0.fail_count - fails_before;
    tests_run++;
    if (fails == 0) begin
      $display("[%0t] test %s: ok", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t] test %s: %0d check failures", $time, name, fails);
    end
    fails_before = dut0.asserts0.fail_count;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    // Reset must hold the outputs at zero against busy inputs
    first                     = 1'b1;
    data                      = small_value();
    taps                      = small_vector();
    bias                      = small_vector();
    cfg.disable_non_linearity = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset                     = 1'b0;
    first                     = 1'b0;
    data                      = '0;
    taps                      = '0;
    bias                      = '0;
    cfg.disable_non_linearity = 1'b1;
    repeat (4) @(posedge clk);
    end_test("reset");
  endtask

  task automatic test_gains();
    run_frame(7, 4'd0, 1'b1, small_vector());
    run_frame(7, 4'd2, 1'b1, small_vector());
    run_frame(7, 4'd5, 1'b1, small_vector());
    flush_frame();
    end_test("parallel sums");
  endtask

  task automatic test_serial();
    run_frame(6, 4'd1, 1'b1, small_vector());
    run_frame(9, 4'd1, 1'b1, small_vector());
    run_frame(6, 4'd1, 1'b1, small_vector());
    run_frame(9, 4'd1, 1'b1, small_vector());
    flush_frame();
    end_test("serialization");
  endtask

  task automatic test_bypass();
    repeat (3) run_frame(8, 4'd0, 1'b1, small_vector());
    flush_frame();
    end_test("sigmoid bypass");
  endtask

  task automatic test_sigmoid();
    repeat (4) run_frame(7, 4'd1, 1'b0, clamp_bias());
    flush_frame();
    end_test("hard sigmoid");
  endtask

  task automatic test_back_to_back();
    for (int f = 0; f < 6; f++) begin
      if (f % 2 == 0) begin
        run_frame(6, 4'd0, 1'b0, clamp_bias());
      end else begin
        run_frame(6, 4'd3, 1'b0, small_vector());
      end
    end
    flush_frame();
    end_test("back to back");
  endtask

  initial begin
    void'($urandom(95685));
    clk                       = 1'b0;
    reset                     = 1'b1;
    first                     = 1'b0;
    data                      = '0;
    taps                      = '0;
    bias                      = '0;
    cfg.tap_gain              = '0;
    cfg.disable_non_linearity = 1'b1;
    tests_run                 = 0;
    tests_failed              = 0;
    fails_before              = 0;
    test_reset();
    test_gains();
    test_serial();
    test_bypass();
    test_sigmoid();
    test_back_to_back();
    $display("Tests run %0d, passed %0d, failed %0d, check failures %0d",
             tests_run, tests_run - tests_failed, tests_failed, dut0.asserts0.fail_count);
    if (tests_failed == 0 && dut0.asserts0.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t: the test sequence did not finish in time", $time);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
hw/nn_layer_pkg.sv
hw/layer_input_stage.sv
hw/neuron_mac.sv
hw/layer_output_stage.sv
hw/hard_sigmoid.sv
hw/fc_layer_top.sv
verification/fc_layer_asserts.sv
verification/fc_layer_tb.sv

//--- Makefile
TOP := fc_layer_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) \
		-Mdir obj_dir -f list.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000000 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
